// ==== design/recorder_lcd_pkg.sv ====
package recorder_lcd_pkg;

    // transport code, status bits 15:12
    typedef enum logic [3:0] {
        rec_none   = 4'd0,
        rec_play   = 4'd1,
        rec_pause  = 4'd2,
        rec_stop   = 4'd3,
        rec_record = 4'd4
    } rec_code_t;

    typedef enum logic [1:0] {
        rec_normal = 2'd0,
        rec_slow   = 2'd1,
        rec_fast   = 2'd2
    } rec_mode_t;

    typedef struct packed {
        rec_code_t  code;      // 15:12
        rec_mode_t  mode;      // 11:10
        logic [3:0] speed;     // 9:6
        logic       interp;    // 5
        logic [4:0] reserved;
    } status_t;

    typedef logic [7:0] lcd_char_t;
    typedef logic [7:0] lcd_addr_t;

    localparam int        LINE_LEN   = 16;     // columns on line 1
    localparam int        LINE2_LEN  = 4;      // columns written on line 2
    localparam lcd_addr_t LINE2_BASE = 8'h40;
    localparam int        TIME_COL   = 12;     // m:ss starts here

    localparam lcd_char_t CHAR_ZERO  = 8'h30;
    localparam lcd_char_t CHAR_SPACE = 8'h20;
    localparam lcd_char_t CHAR_COLON = 8'h3a;
    localparam lcd_char_t CHAR_SLASH = 8'h2f;
    localparam lcd_char_t CHAR_STAR  = 8'h2a;
    localparam lcd_char_t CHAR_AT    = 8'h40;

endpackage

// ==== design/elapsed_time_if.sv ====
`timescale 1ns/10ps

interface elapsed_time_if;

    logic       tick;      // one cycle per second
    logic [3:0] min;       // single digit, wraps at 10
    logic [2:0] sec_ten;
    logic [3:0] sec_one;

    modport timer (
        output tick, min, sec_ten, sec_one
    );

    modport view (
        input tick, min, sec_ten, sec_one
    );

endinterface

// ==== design/elapsed_timer.sv ====
`timescale 1ns/10ps

module elapsed_timer
    import recorder_lcd_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic          i_clk,
    input  logic          i_rst,
    input  rec_code_t     i_code,
    elapsed_time_if.timer o_time
);

    localparam int               CNT_W    = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);

    rec_code_t        prev_code;
    logic [CNT_W-1:0] cnt;
    logic             code_chg;
    logic             sec_done;

    assign code_chg = (i_code != prev_code);
    assign sec_done = (cnt == CNT_LAST);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            prev_code      <= rec_none;
            cnt            <= '0;
            o_time.tick    <= 1'b0;
            o_time.min     <= 4'd0;
            o_time.sec_ten <= 3'd0;
            o_time.sec_one <= 4'd0;
        end else begin
            prev_code   <= i_code;
            o_time.tick <= 1'b0;
            if (code_chg) begin
                // new transport code restarts the clock at 0:00
                cnt            <= '0;
                o_time.min     <= 4'd0;
                o_time.sec_ten <= 3'd0;
                o_time.sec_one <= 4'd0;
            end else if (sec_done) begin
                cnt         <= '0;
                o_time.tick <= 1'b1;
                if (o_time.sec_one == 4'd9) begin
                    o_time.sec_one <= 4'd0;
                    if (o_time.sec_ten == 3'd5) begin
                        o_time.sec_ten <= 3'd0;
                        if (o_time.min == 4'd9) begin
                            o_time.min <= 4'd0;       // wrap after 9:59
                        end else begin
                            o_time.min <= o_time.min + 4'd1;
                        end
                    end else begin
                        o_time.sec_ten <= o_time.sec_ten + 3'd1;
                    end
                end else begin
                    o_time.sec_one <= o_time.sec_one + 4'd1;
                end
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== design/screen_text_composer.sv ====
`timescale 1ns/10ps

module screen_text_composer
    import recorder_lcd_pkg::*;
(
    input  status_t       i_status,
    input  logic          i_line,
    input  logic [3:0]    i_col,
    elapsed_time_if.view  i_time,
    output lcd_char_t     o_char
);

    localparam int LBL_W = 8 * LINE_LEN;

    // labels padded with spaces to a full line, leftmost character in the top byte
    localparam logic [LBL_W-1:0] LBL_IDLE   = {"Idle...",   {9{CHAR_SPACE}}};
    localparam logic [LBL_W-1:0] LBL_PLAY   = {"Play",      {12{CHAR_SPACE}}};
    localparam logic [LBL_W-1:0] LBL_PAUSE  = {"Pause",     {11{CHAR_SPACE}}};
    localparam logic [LBL_W-1:0] LBL_STOP   = {"Stop",      {12{CHAR_SPACE}}};
    localparam logic [LBL_W-1:0] LBL_RECORD = {"Recording", {7{CHAR_SPACE}}};

    logic [LBL_W-1:0] label;
    logic             show_time;
    logic             in_time_field;
    logic [1:0]       time_idx;
    lcd_char_t        label_char;
    lcd_char_t        time_char;
    lcd_char_t        line1_char;
    lcd_char_t        line2_char;

    always_comb begin
        case (i_status.code)
            rec_play:   label = LBL_PLAY;
            rec_pause:  label = LBL_PAUSE;
            rec_stop:   label = LBL_STOP;
            rec_record: label = LBL_RECORD;
            default:    label = LBL_IDLE;     // none and unknown codes
        endcase
    end

    assign label_char = label[8 * (LINE_LEN - 1 - int'(i_col)) +: 8];

    assign show_time     = (i_status.code == rec_play) || (i_status.code == rec_record);
    assign in_time_field = (i_col >= 4'(TIME_COL));
    assign time_idx      = 2'(i_col - 4'(TIME_COL));

    // m:ss in columns 12..15
    always_comb begin
        case (time_idx)
            2'd0:    time_char = CHAR_ZERO + lcd_char_t'(i_time.min);
            2'd1:    time_char = CHAR_COLON;
            2'd2:    time_char = CHAR_ZERO + lcd_char_t'(i_time.sec_ten);
            default: time_char = CHAR_ZERO + lcd_char_t'(i_time.sec_one);
        endcase
    end

    assign line1_char = (show_time && in_time_field) ? time_char : label_char;

    // speed line, only columns 0..3 are ever addressed
    always_comb begin
        case (i_col)
            4'd0: begin
                if (i_status.mode == rec_slow) begin
                    line2_char = CHAR_SLASH;
                end else begin
                    line2_char = CHAR_STAR;
                end
            end
            4'd1: begin
                line2_char = CHAR_ZERO + lcd_char_t'(i_status.speed);  // past '9' above 9
            end
            4'd3: begin
                if (i_status.interp) begin
                    line2_char = CHAR_AT;
                end else begin
                    line2_char = CHAR_ZERO;
                end
            end
            default: begin
                line2_char = CHAR_SPACE;
            end
        endcase
    end

    assign o_char = i_line ? line2_char : line1_char;

endmodule

// ==== design/lcd_write_sequencer.sv ====
`timescale 1ns/10ps

module lcd_write_sequencer
    import recorder_lcd_pkg::*;
(
    input  logic          i_clk,
    input  logic          i_rst,
    input  status_t       i_status,
    elapsed_time_if.view  i_time,
    input  logic          i_busy,
    input  lcd_char_t     i_char,
    output logic          o_line,
    output logic [3:0]    o_col,
    output lcd_addr_t     o_address,
    output lcd_char_t     o_character,
    output logic          o_start
);

    status_t   prev_status;
    logic      req;           // refresh pending
    logic      running;       // pass in progress
    logic      gap;           // write issued last cycle
    logic      status_chg;
    logic      refresh_tick;
    logic      can_write;
    logic      line1_end;
    logic      pass_end;
    lcd_addr_t cur_addr;

    assign status_chg   = (i_status != prev_status);
    assign refresh_tick = i_time.tick &&
                          ((i_status.code == rec_play) || (i_status.code == rec_record));
    assign can_write    = running && !i_busy && !gap && !status_chg;

    assign line1_end = !o_line && (o_col == 4'(LINE_LEN - 1));
    assign pass_end  = o_line && (o_col == 4'(LINE2_LEN - 1));

    assign cur_addr = o_line ? (LINE2_BASE + lcd_addr_t'(o_col)) : lcd_addr_t'(o_col);

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            prev_status <= '0;
            req         <= 1'b1;      // idle screen after reset
            running     <= 1'b0;
            gap         <= 1'b0;
            o_start     <= 1'b0;
            o_line      <= 1'b0;
            o_col       <= 4'd0;
        end else begin
            prev_status <= i_status;
            gap         <= can_write;
            o_start     <= can_write;
            if (status_chg) begin
                // abort, restart from line 1 column 0
                req     <= 1'b1;
                running <= 1'b0;
            end else if (req && !running) begin
                req     <= refresh_tick;
                running <= 1'b1;
                o_line  <= 1'b0;
                o_col   <= 4'd0;
            end else begin
                if (refresh_tick) begin
                    req <= 1'b1;
                end
                if (can_write) begin
                    if (pass_end) begin
                        running <= 1'b0;
                    end else if (line1_end) begin
                        o_line <= 1'b1;
                        o_col  <= 4'd0;
                    end else begin
                        o_col <= o_col + 4'd1;
                    end
                end
            end
        end
    end

    // payload follows the start strobe
    always_ff @(posedge i_clk) begin
        if (can_write) begin
            o_address   <= cur_addr;
            o_character <= i_char;
        end
    end

endmodule

// ==== design/recorder_lcd_top.sv ====
`timescale 1ns/10ps

module recorder_lcd_top
    import recorder_lcd_pkg::*;
#(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic [15:0] i_status,
    input  logic        i_busy,
    output logic [7:0]  o_address,
    output logic [7:0]  o_character,
    output logic        o_start
);

    status_t    status_q;
    logic       scr_line;
    logic [3:0] scr_col;
    lcd_char_t  scr_char;

    elapsed_time_if u_time_if ();

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            status_q <= '0;           // none code, idle screen
        end else begin
            status_q <= status_t'(i_status);
        end
    end

    elapsed_timer #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_elapsed_timer (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_code (status_q.code),
        .o_time (u_time_if)
    );

    screen_text_composer u_screen_text_composer (
        .i_status (status_q),
        .i_line   (scr_line),
        .i_col    (scr_col),
        .i_time   (u_time_if),
        .o_char   (scr_char)
    );

    lcd_write_sequencer u_lcd_write_sequencer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_status    (status_q),
        .i_time      (u_time_if),
        .i_busy      (i_busy),
        .i_char      (scr_char),
        .o_line      (scr_line),
        .o_col       (scr_col),
        .o_address   (o_address),
        .o_character (o_character),
        .o_start     (o_start)
    );

endmodule

// ==== bench/tb_recorder_lcd.sv ====
`timescale 1ns/10ps

module tb_recorder_lcd;

    localparam int TICKS      = 8;
    localparam int RST_CYCLES = 8;
    localparam int STEP_SLACK = 150;     // pass end wait plus busy stretch per step

    logic        i_clk;
    logic        i_rst;
    logic [15:0] i_status;
    logic        i_busy;
    logic [7:0]  o_address;
    logic [7:0]  o_character;
    logic        o_start;

    logic [15:0]  st_q[$];
    int           busy_q[$];
    int           wait_q[$];
    logic [127:0] line1_q[$];
    logic [31:0]  line2_q[$];

    logic [7:0] screen [0:1][0:15];
    integer     seed;
    int         errors;
    int         failed_steps;
    int         cycle_cnt;
    int         cycle_limit;
    int         busy_cnt;
    int         force_cnt;
    logic       busy_random;
    logic       last_start;
    logic       pass_open;           // between writes to 0x00 and 0x43

    recorder_lcd_top #(
        .TICKS_PER_SEC (TICKS)
    ) u_recorder_lcd_top (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_status    (i_status),
        .i_busy      (i_busy),
        .o_address   (o_address),
        .o_character (o_character),
        .o_start     (o_start)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // watchdog on rising edges, limit set once the trace is read
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: trace not finished after %0d cycles", cycle_cnt);
        $display("Errors found");
        $finish;
    end

    task automatic read_trace;
        int           fd;
        int           n;
        string        text;
        logic [15:0]  st;
        int           b;
        int           w;
        logic [127:0] l1;
        logic [31:0]  l2;
        fd = $fopen("bench/recorder_lcd_trace.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the trace file bench/recorder_lcd_trace.txt");
            errors++;
        end
        if (fd != 0) begin
            while ($fgets(text, fd) != 0) begin
                if (text.len() > 1 && text.getc(0) != 8'h23) begin
                    n = $sscanf(text, "%h %d %d %s %s", st, b, w, l1, l2);
                    assert (n == 5) else begin
                        $display("trace line could not be parsed: %s", text);
                        errors++;
                    end
                    if (n == 5) begin
                        st_q.push_back(st);
                        busy_q.push_back(b);
                        wait_q.push_back(w);
                        line1_q.push_back(l1);
                        line2_q.push_back(l2);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [7:0] expected_char(input logic [127:0] text, input int pos,
                                                 input int len);
        logic [7:0] c;
        c = text[8 * (len - 1 - pos) +: 8];
        if (c == 8'h5f) begin
            c = 8'h20;                   // underscore stands for a space
        end
        return c;
    endfunction

    task automatic record_write(input logic [7:0] addr, input logic [7:0] ch);
        logic valid;
        valid = (addr < 8'h10) || (addr >= 8'h40 && addr < 8'h44);
        assert (valid) else begin
            $display("write to address %h outside the screen at time %0t", addr, $time);
            errors++;
        end
        if (addr < 8'h10) begin
            screen[0][addr[3:0]] = ch;
        end else if (valid) begin
            screen[1][addr[3:0]] = ch;
        end
        if (addr == 8'h00) begin
            pass_open = 1'b1;
        end else if (addr == 8'h43) begin
            pass_open = 1'b0;
        end
    endtask

    task automatic update_busy;
        if (force_cnt > 0) begin
            force_cnt--;
        end else if (busy_random && o_start) begin
            busy_cnt = int'($unsigned($random(seed)) % 4);   // 0 to 3 cycles
        end else if (busy_cnt > 0) begin
            busy_cnt--;
        end
        i_busy = (force_cnt > 0) || (busy_cnt > 0);
    endtask

    task automatic run_cycle;
        @(negedge i_clk);
        assert (!(o_start && i_busy)) else begin
            $display("write started while busy was high at time %0t", $time);
            errors++;
        end
        assert (!(o_start && last_start)) else begin
            $display("write started in the cycle after a write at time %0t", $time);
            errors++;
        end
        if (force_cnt > 0) begin
            assert (!o_start) else begin
                $display("write started while busy was held high at time %0t", $time);
                errors++;
            end
        end
        if (o_start) begin
            record_write(o_address, o_character);
        end
        update_busy;
        last_start = o_start;
    endtask

    task automatic check_char(input int ln, input int col, input logic [7:0] exp_ch);
        assert (screen[ln][col] === exp_ch) else begin
            $display("error time %0t screen[%0d][%0d]: got %h expected %h",
                     $time, ln, col, screen[ln][col], exp_ch);
            errors++;
        end
    endtask

    task automatic run_step(input int idx);
        int errs_before;
        int c;
        errs_before = errors;
        i_status    = st_q[idx];
        force_cnt   = (busy_q[idx] > 0) ? busy_q[idx] : 0;
        busy_random = (busy_q[idx] != 0);
        if (busy_q[idx] >= 0) begin
            busy_cnt = 0;
        end
        i_busy = (force_cnt > 0) || (busy_cnt > 0);
        repeat (wait_q[idx]) run_cycle;
        while (pass_open) run_cycle;     // let the running pass finish
        for (c = 0; c < 16; c++) begin
            check_char(0, c, expected_char(line1_q[idx], c, 16));
        end
        for (c = 0; c < 4; c++) begin
            check_char(1, c, expected_char({96'd0, line2_q[idx]}, c, 4));
        end
        if (errors == errs_before) begin
            $display("step %0d status %h busy %0d: pass", idx + 1, st_q[idx], busy_q[idx]);
        end else begin
            failed_steps++;
            $display("step %0d status %h busy %0d: FAIL", idx + 1, st_q[idx], busy_q[idx]);
        end
    endtask

    initial begin
        int i;
        int l;
        int total_wait;
        i_rst        = 1'b1;
        i_status     = 16'h0000;
        i_busy       = 1'b0;
        seed         = 32'h8c156df9;
        errors       = 0;
        failed_steps = 0;
        busy_cnt     = 0;
        force_cnt    = 0;
        busy_random  = 1'b1;
        last_start   = 1'b0;
        pass_open    = 1'b0;
        for (l = 0; l < 2; l++) begin
            for (i = 0; i < 16; i++) begin
                screen[l][i] = 8'h80 + 8'(l * 16 + i);   // non-ASCII until written
            end
        end
        read_trace;
        assert (st_q.size() > 0) else begin
            $display("trace holds no steps");
            errors++;
        end
        total_wait = 0;
        for (i = 0; i < wait_q.size(); i++) begin
            total_wait += wait_q[i];
        end
        cycle_limit = total_wait + STEP_SLACK * st_q.size() + 4 * RST_CYCLES;
        repeat (RST_CYCLES) begin
            run_cycle;
            assert (!o_start) else begin
                $display("start strobe high during reset at time %0t", $time);
                errors++;
            end
        end
        i_rst = 1'b0;
        for (i = 0; i < st_q.size(); i++) begin
            run_step(i);
        end
        $display("%0d steps, %0d failed, %0d check failures", st_q.size(), failed_steps,
                 errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== bench/recorder_lcd_trace.txt ====
# status(hex) busy wait line1 line2, underscore in the text is a space
# busy -1 random 0..3 after each start, 0 never, n>0 held high n cycles then random
0000 -1 100  Idle..._________ *0_0
2160 -1 120  Pause___________ *5_@
34C0 -1 120  Stop____________ /3_0
9B20 -1 120  Idle..._________ *<_@
07C0 40 160  Idle..._________ /?_0
6760 -1 120  Idle..._________ /=_@
8D00 -1 120  Idle..._________ *4_0
F280 -1 120  Idle..._________ *:_0
2B80 25 150  Pause___________ *>_0
1240 0  20   Play________0:03 *9_0
1240 0  418  Play________0:58 *9_0
1240 0  20   Play________1:03 *9_0
1240 0  4258 Play________9:58 *9_0
1240 0  20   Play________0:03 *9_0
44A0 0  20   Recording___0:03 /2_@
3000 -1 120  Stop____________ *0_0
0000 -1 100  Idle..._________ *0_0

// ==== sim.f ====
design/recorder_lcd_pkg.sv
design/elapsed_time_if.sv
design/elapsed_timer.sv
design/screen_text_composer.sv
design/lcd_write_sequencer.sv
design/recorder_lcd_top.sv
bench/tb_recorder_lcd.sv

// ==== Bender.yml ====
package:
  name: recorder_lcd

sources:
  - files:
      - design/recorder_lcd_pkg.sv
      - design/elapsed_time_if.sv
      - design/elapsed_timer.sv
      - design/screen_text_composer.sv
      - design/lcd_write_sequencer.sv
      - design/recorder_lcd_top.sv
  - target: simulation
    files:
      - bench/tb_recorder_lcd.sv
